//--- Bender.yml
package:
  name: extint

sources:
  - include_dirs:
      - include
    files:
      - logic/sfr_map_pkg.sv
      - logic/extint_pkg.sv
      - logic/extint_sfr.sv
      - logic/pin_sampler.sv
      - logic/tcon_bank.sv
      - logic/ircon_bank.sv
      - logic/extint_top.sv
  - target: test
    files:
      - bench/extint_checker.sv
      - bench/extint_tb.sv

//--- bench/extint_checker.sv
`timescale 1ns/10ps
`default_nettype none

module extint_checker
  import sfr_map_pkg::*, extint_pkg::*;
(
  input  wire logic                clkper,
  input  wire logic                rst,
  input  wire logic                newinstr,
  input  wire logic [NUM_PINS-1:0] pins,
  input  wire logic [NUM_PINS-1:0] ack,
  input  wire sfr_bus_t            sfr,
  input  wire tcon_stat_t          tcon,
  input  wire ircon_stat_t         ircon,
  input  wire logic [2:0]          test_id,   // 7 once the sequence is over
  output int                       n_pass,
  output int                       n_fail
);

  typedef struct packed {
    logic [7:0] smp;     // Last pin sample
    logic [1:0] it;
    logic [1:0] fr;
    logic [1:0] ie;
    logic [1:0] tpend;   // Int 0/1 falling edge held
    logic [1:0] clr;     // Int 0/1 ack hold
    logic [5:0] ipend;   // Int 2..7 edge held
    logic [5:0] iex;
  } model_t;

  model_t     m;
  logic       synced;    // Model valid from the first reset edge
  logic [2:0] cur_id;
  int         errs;
  int         checks;

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd0:    return "reset_values";
      3'd1:    return "sfr_write";
      3'd2:    return "level_mode";
      3'd3:    return "edge_ack";
      3'd4:    return "select_edge";
      3'd5:    return "random_pins";
      default: return "idle";
    endcase
  endfunction

  // ----------------------------------------
  // Reference model, one clock edge
  // ----------------------------------------
  function automatic model_t next_model(input model_t m0, input logic [7:0] p,
                                        input logic [7:0] a, input logic ni,
                                        input sfr_bus_t b);
    model_t     n;
    logic [7:0] rise;
    logic [7:0] fall;
    logic [5:0] trig;
    logic [5:0] ir_data;
    logic       w_tcon;
    logic       w_t2con;
    logic       w_ircon;
    n       = m0;
    rise    = p & ~m0.smp;
    fall    = ~p & m0.smp;
    w_tcon  = b.we && (b.addr == TCON_ID);
    w_t2con = b.we && (b.addr == T2CON_ID);
    w_ircon = b.we && (b.addr == IRCON_ID);
    ir_data = {b.data[0], b.data[5:1]};   // IEX7 sits at bit 0
    trig    = {rise[7:4], m0.fr[1] ? rise[3] : fall[3], m0.fr[0] ? rise[2] : fall[2]};
    n.smp   = p;
    if (w_tcon)
      n.it = {b.data[2], b.data[0]};
    if (w_t2con)
      n.fr = {b.data[6], b.data[5]};
    for (int i = 0; i < 2; i++)
    begin
      if (w_tcon)
        n.ie[i] = b.data[2*i+1];          // Write beats hardware
      else if (!m0.it[i])
        n.ie[i] = ~p[i];                  // Level mode
      else if (a[i] || m0.clr[i])
        n.ie[i] = 1'b0;
      else if (m0.tpend[i] || fall[i])
        n.ie[i] = 1'b1;
      n.tpend[i] = fall[i] ? 1'b1 : ((ni || a[i]) ? 1'b0 : m0.tpend[i]);
      n.clr[i]   = a[i] ? 1'b1 : (ni ? 1'b0 : m0.clr[i]);
    end
    for (int i = 0; i < 6; i++)
    begin
      n.ipend[i] = trig[i] ? 1'b1 : ((ni || a[i+2]) ? 1'b0 : m0.ipend[i]);
      if (w_ircon)
        n.iex[i] = ir_data[i];
      else if (a[i+2])
        n.iex[i] = 1'b0;
      else if (m0.ipend[i])
        n.iex[i] = 1'b1;                  // Flag trails the latch by one
    end
    return n;
  endfunction

  task automatic close_test();
    if (errs == 0)
    begin
      $display("pass %s after %0d checks", test_name(cur_id), checks);
      n_pass++;
    end
    else
    begin
      $display("fail %s with %0d mismatches", test_name(cur_id), errs);
      n_fail++;
    end
    errs   = 0;
    checks = 0;
  endtask

  initial
  begin
    n_pass = 0;
    n_fail = 0;
    synced = 1'b0;
    cur_id = 3'd0;
    errs   = 0;
    checks = 0;
  end

  // Model steps on the same edge as the DUT
  always @(posedge clkper)
  begin
    if (rst)
    begin
      m      = '0;
      m.smp  = 8'h0c;     // Pins 2 and 3 idle high
      synced = 1'b1;
    end
    else
      m = next_model(m, pins, ack, newinstr, sfr);
  end

  // ----------------------------------------
  // Compare mid cycle, outputs settled
  // ----------------------------------------
  always @(negedge clkper)
  begin
    if (test_id != cur_id)
    begin
      if (cur_id < 3'd6)
        close_test();
      cur_id = test_id;
    end
    if (synced && cur_id < 3'd6)
    begin
      checks++;
      if ({tcon, ircon} !== {m.ie, m.it, m.iex, m.fr})
      begin
        errs++;
        $display("error %s expected tcon %b ircon %b actual tcon %b ircon %b",
                 test_name(cur_id), {m.ie, m.it}, {m.iex, m.fr}, tcon, ircon);
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/extint_tb.sv
`timescale 1ns/10ps
`default_nettype none

module extint_tb
  import sfr_map_pkg::*, extint_pkg::*;
();

  logic                clkper;
  logic                rst;
  logic                newinstr;
  logic [NUM_PINS-1:0] pins;
  logic [NUM_PINS-1:0] ack;
  sfr_bus_t            sfr;
  tcon_stat_t          tcon;
  ircon_stat_t         ircon;
  logic [7:0]          flags;     // Index is the interrupt number
  logic [2:0]          test_id;
  int                  n_pass;
  int                  n_fail;
  int                  stalls;
  int                  n;
  logic [31:0]         lfsr;
  logic [31:0]         r1;
  logic [31:0]         r2;
  logic [31:0]         r3;
  logic [31:0]         r4;

  assign flags = {ircon.iex, tcon.ie};

  extint_top dut (
    .clkper   (clkper),
    .rst      (rst),
    .newinstr (newinstr),
    .pins     (pins),
    .ack      (ack),
    .sfr      (sfr),
    .tcon     (tcon),
    .ircon    (ircon)
  );

  extint_checker chk (
    .clkper   (clkper),
    .rst      (rst),
    .newinstr (newinstr),
    .pins     (pins),
    .ack      (ack),
    .sfr      (sfr),
    .tcon     (tcon),
    .ircon    (ircon),
    .test_id  (test_id),
    .n_pass   (n_pass),
    .n_fail   (n_fail)
  );

  always #10 clkper = ~clkper;   // 20 ns period

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic take_bits(input int cnt, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < cnt; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};   // One step per bit
    end
  endtask

  function automatic sfr_bus_t wr_bus(input logic [6:0] addr, input logic [7:0] data);
    sfr_bus_t b;
    b.addr = addr;
    b.data = data;
    b.we   = 1'b1;
    return b;
  endfunction

  // Pulses last one cycle, pins hold
  task automatic step(input logic [7:0] p, input logic [7:0] a, input logic ni,
                      input sfr_bus_t b);
    @(posedge clkper);
    pins     <= p;
    ack      <= a;
    newinstr <= ni;
    sfr      <= b;
    @(posedge clkper);
    ack      <= '0;
    newinstr <= 1'b0;
    sfr      <= '0;
  endtask

  task automatic set_pin(input int ch, input logic v);
    logic [7:0] p;
    p     = pins;
    p[ch] = v;
    step(p, '0, 1'b0, '0);
  endtask

  task automatic start_test(input logic [2:0] id);
    @(posedge clkper);
    test_id <= id;
  endtask

  task automatic wait_flag(input int idx, input logic v);
    int k;
    k = 0;
    do
    begin
      @(negedge clkper);
      k++;
    end
    while (flags[idx] !== v && k < 8);
    if (flags[idx] !== v)
    begin
      $display("timeout: flag of interrupt %0d never reached %b", idx, v);
      stalls++;
    end
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial
  begin
    clkper   = 1'b0;
    rst      = 1'b1;
    newinstr = 1'b0;
    pins     = 8'h0f;   // Ints 0..3 idle high
    ack      = '0;
    sfr      = '0;
    test_id  = 3'd0;
    stalls   = 0;
    lfsr     = 32'hae3c285d;
    repeat (4) @(posedge clkper);
    rst <= 1'b0;
    repeat (4) step(pins, '0, 1'b0, '0);

    start_test(3'd1);
    step(pins, '0, 1'b0, wr_bus(TCON_ID, 8'h0f));
    step(pins, '0, 1'b0, wr_bus(T2CON_ID, 8'h60));
    step(pins, '0, 1'b0, wr_bus(IRCON_ID, 8'h3f));
    step(pins, 8'hfc, 1'b0, wr_bus(IRCON_ID, 8'h15));   // Write against ack
    step(pins, '0, 1'b0, wr_bus(TCON_ID, 8'h00));
    step(pins, '0, 1'b0, wr_bus(T2CON_ID, 8'h00));
    step(pins, '0, 1'b0, wr_bus(IRCON_ID, 8'h00));

    start_test(3'd2);
    for (int ch = 0; ch < 2; ch++)
    begin
      set_pin(ch, 1'b0);
      wait_flag(ch, 1'b1);
      set_pin(ch, 1'b1);
      wait_flag(ch, 1'b0);
    end

    start_test(3'd3);
    step(pins, '0, 1'b0, wr_bus(TCON_ID, 8'h05));   // Both edge mode
    set_pin(0, 1'b0);
    wait_flag(0, 1'b1);
    set_pin(0, 1'b1);
    step(pins, 8'h01, 1'b0, '0);
    wait_flag(0, 1'b0);
    set_pin(0, 1'b0);        // Second edge while held clear
    set_pin(0, 1'b1);
    step(pins, '0, 1'b1, '0);
    set_pin(0, 1'b0);
    wait_flag(0, 1'b1);
    set_pin(0, 1'b1);
    step(pins, 8'h01, 1'b1, wr_bus(TCON_ID, 8'h00));

    start_test(3'd4);
    for (int ch = 2; ch < 4; ch++)
    begin
      set_pin(ch, 1'b0);     // Falling edge selected
      wait_flag(ch, 1'b1);
      step(pins, 8'h01 << ch, 1'b0, '0);
      wait_flag(ch, 1'b0);
      set_pin(ch, 1'b1);     // Wrong edge, no request
      step(pins, '0, 1'b0, wr_bus(T2CON_ID, (ch == 2) ? 8'h20 : 8'h40));
      set_pin(ch, 1'b0);
      set_pin(ch, 1'b1);
      wait_flag(ch, 1'b1);
      step(pins, 8'h01 << ch, 1'b1, wr_bus(T2CON_ID, 8'h00));
      wait_flag(ch, 1'b0);
    end

    start_test(3'd5);
    for (int c = 0; c < 400; c++)
    begin
      take_bits(16, r1);
      take_bits(16, r2);
      take_bits(7, r3);
      take_bits(8, r4);
      @(posedge clkper);
      pins     <= pins ^ (r1[7:0] & r1[15:8]);   // Roughly two pins move
      ack      <= r2[7:0] & r2[15:8];
      newinstr <= &r3[1:0];
      sfr.we   <= (r3[4:2] == 3'd0);
      sfr.addr <= r3[6] ? (r3[5] ? 7'h10 : IRCON_ID) : (r3[5] ? T2CON_ID : TCON_ID);
      sfr.data <= r4[7:0];
    end
    step(pins, '0, 1'b0, '0);

    start_test(3'd7);
    n = 0;
    while (n_pass + n_fail < 6 && n < 10)
    begin
      @(negedge clkper);
      n++;
    end
    if (n_pass + n_fail < 6)
    begin
      $display("timeout: checker closed only %0d of 6 tests", n_pass + n_fail);
      stalls++;
    end
    $display("tests passed %0d, failed %0d, timeouts %0d", n_pass, n_fail, stalls);
    if (n_pass == 6 && n_fail == 0 && stalls == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- include/extint_defs.svh
`ifndef EXTINT_DEFS_SVH
`define EXTINT_DEFS_SVH

// True when the SFR bus writes the register at address id
`define EXTINT_SFR_HIT(bus, id) ((bus).we && ((bus).addr == (id)))

`endif

//--- list.f
+incdir+include
logic/sfr_map_pkg.sv
logic/extint_pkg.sv
logic/extint_sfr.sv
logic/pin_sampler.sv
logic/tcon_bank.sv
logic/ircon_bank.sv
logic/extint_top.sv
bench/extint_checker.sv
bench/extint_tb.sv

//--- logic/extint_pkg.sv
`default_nettype none

package extint_pkg;
  import sfr_map_pkg::*;

  localparam int NUM_PINS  = 8;    // Interrupt pins watched
  localparam int NUM_TCON  = 2;    // Ints 0 and 1
  localparam int NUM_IRCON = 6;    // Ints 2 to 7

  // Pin indices
  localparam int PIN_INT0 = 0;
  localparam int PIN_INT1 = 1;
  localparam int PIN_INT2 = 2;
  localparam int PIN_INT3 = 3;
  localparam int PIN_INT4 = 4;
  localparam int PIN_INT5 = 5;
  localparam int PIN_INT6 = 6;
  localparam int PIN_INT7 = 7;

  // Pins 2 and 3 assumed idle high
  localparam logic [NUM_PINS-1:0] PIN_SAMPLE_RV = 8'b0000_1100;

  // ----------------------------------------
  // Structs between blocks
  // ----------------------------------------
  typedef struct packed {
    logic [SFR_ADDR_W-1:0] addr;
    logic [SFR_DATA_W-1:0] data;
    logic                  we;     // Write strobe
  } sfr_bus_t;

  typedef struct packed {
    logic [NUM_PINS-1:0] rise;     // One pulse per pin
    logic [NUM_PINS-1:0] fall;
  } pin_edges_t;

  typedef struct packed {
    logic                 wr;      // Flag write this cycle
    logic [NUM_IRCON-1:0] data;    // Sized for the wider bank
  } flag_wr_t;

  typedef struct packed {
    logic [NUM_TCON-1:0] ie;
    logic [NUM_TCON-1:0] it;
  } tcon_stat_t;

  typedef struct packed {
    logic [NUM_IRCON-1:0] iex;     // Index 0 is int 2
    logic [1:0]           fr;
  } ircon_stat_t;

endpackage

`default_nettype wire

//--- logic/extint_sfr.sv
`timescale 1ns/10ps
`default_nettype none

`include "extint_defs.svh"

module extint_sfr
  import sfr_map_pkg::*, extint_pkg::*;
(
  input  wire logic          clkper,
  input  wire logic          rst,
  input  wire sfr_bus_t      sfr,
  output flag_wr_t           tcon_wr,   // Flag strobe to tcon_bank
  output flag_wr_t           ircon_wr,  // Flag strobe to ircon_bank
  output logic [NUM_TCON-1:0] it,       // Edge mode when set
  output logic [1:0]          fr        // Rising edge when set
);

  logic hit_tcon;
  logic hit_t2con;
  logic hit_ircon;

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  assign hit_tcon  = `EXTINT_SFR_HIT(sfr, TCON_ID);
  assign hit_t2con = `EXTINT_SFR_HIT(sfr, T2CON_ID);
  assign hit_ircon = `EXTINT_SFR_HIT(sfr, IRCON_ID);

  // Mode and edge select bits live here
  always_ff @(posedge clkper)
  begin
    if (rst)
    begin
      it <= {TCON_RV[TCON_IT1], TCON_RV[TCON_IT0]};
      fr <= {T2CON_RV[T2CON_I3FR], T2CON_RV[T2CON_I2FR]};
    end
    else
    begin
      if (hit_tcon)
        it <= {sfr.data[TCON_IT1], sfr.data[TCON_IT0]};
      if (hit_t2con)
        fr <= {sfr.data[T2CON_I3FR], sfr.data[T2CON_I2FR]};
    end
  end

  // ----------------------------------------
  // Flag strobes, same cycle as the write
  // ----------------------------------------
  assign tcon_wr = '{
    wr:   hit_tcon,
    data: {{(NUM_IRCON-NUM_TCON){1'b0}}, sfr.data[TCON_IE1], sfr.data[TCON_IE0]}
  };

  // Reorder so bit 0 is int 2 and bit 5 is int 7
  assign ircon_wr = '{
    wr:   hit_ircon,
    data: {sfr.data[IRCON_IEX7], sfr.data[IRCON_IEX6], sfr.data[IRCON_IEX5],
           sfr.data[IRCON_IEX4], sfr.data[IRCON_IEX3], sfr.data[IRCON_IEX2]}
  };

  // One register per write, so the banks never see two strobes
  a_one_strobe: assert property (
    @(posedge clkper) disable iff (rst) !(tcon_wr.wr && ircon_wr.wr)
  );

endmodule

`default_nettype wire

//--- logic/extint_top.sv
`timescale 1ns/10ps
`default_nettype none

module extint_top
  import extint_pkg::*;
(
  input  wire logic                clkper,
  input  wire logic                rst,
  input  wire logic                newinstr,   // Start of CPU instruction
  input  wire logic [NUM_PINS-1:0] pins,       // Interrupt pin levels
  input  wire logic [NUM_PINS-1:0] ack,        // Per interrupt acknowledge
  input  wire sfr_bus_t            sfr,
  output tcon_stat_t               tcon,
  output ircon_stat_t              ircon
);

  flag_wr_t            tcon_wr;
  flag_wr_t            ircon_wr;
  logic [NUM_TCON-1:0] it;
  logic [1:0]          fr;
  pin_edges_t          edges;

  // ----------------------------------------
  // SFR decode and pin sampling
  // ----------------------------------------
  extint_sfr u_sfr (
    .clkper   (clkper),
    .rst      (rst),
    .sfr      (sfr),
    .tcon_wr  (tcon_wr),
    .ircon_wr (ircon_wr),
    .it       (it),
    .fr       (fr)
  );

  pin_sampler u_sampler (
    .clkper (clkper),
    .rst    (rst),
    .pins   (pins),
    .edges  (edges)
  );

  // ----------------------------------------
  // Flag banks
  // ----------------------------------------
  tcon_bank u_tcon (
    .clkper   (clkper),
    .rst      (rst),
    .newinstr (newinstr),
    .lvl      (pins[PIN_INT1:PIN_INT0]),        // Level mode needs raw pins
    .fall     (edges.fall[PIN_INT1:PIN_INT0]),
    .ack      (ack[PIN_INT1:PIN_INT0]),
    .it       (it),
    .wr       (tcon_wr),
    .stat     (tcon)
  );

  ircon_bank u_ircon (
    .clkper   (clkper),
    .rst      (rst),
    .newinstr (newinstr),
    .edges    (edges),
    .ack      (ack[PIN_INT7:PIN_INT2]),
    .fr       (fr),
    .wr       (ircon_wr),
    .stat     (ircon)
  );

endmodule

`default_nettype wire

//--- logic/ircon_bank.sv
`timescale 1ns/10ps
`default_nettype none

module ircon_bank
  import sfr_map_pkg::*, extint_pkg::*;
(
  input  wire logic                 clkper,
  input  wire logic                 rst,
  input  wire logic                 newinstr,  // Start of CPU instruction
  input  wire pin_edges_t           edges,
  input  wire logic [NUM_IRCON-1:0] ack,       // Bit 0 is int 2
  input  wire logic [1:0]           fr,        // Edge select for ints 2, 3
  input  wire flag_wr_t             wr,
  output ircon_stat_t               stat
);

  logic [NUM_IRCON-1:0] trig;   // Selected edge per channel
  logic [NUM_IRCON-1:0] pend;   // Edge held until taken
  logic [NUM_IRCON-1:0] iex;    // Request flags

  // ----------------------------------------
  // Edge select
  // ----------------------------------------
  assign trig[0] = fr[0] ? edges.rise[PIN_INT2] : edges.fall[PIN_INT2];
  assign trig[1] = fr[1] ? edges.rise[PIN_INT3] : edges.fall[PIN_INT3];
  assign trig[NUM_IRCON-1:2] = edges.rise[PIN_INT7:PIN_INT4];   // Rising only

  // Pending latches
  always_ff @(posedge clkper)
  begin
    if (rst)
      pend <= '0;
    else
    begin
      for (int i = 0; i < NUM_IRCON; i++)
      begin
        if (trig[i])
          pend[i] <= 1'b1;
        else if (newinstr || ack[i])
          pend[i] <= 1'b0;
      end
    end
  end

  // ----------------------------------------
  // Request flags
  // ----------------------------------------
  always_ff @(posedge clkper)
  begin
    if (rst)
      iex <= {IRCON_RV[IRCON_IEX7], IRCON_RV[IRCON_IEX6], IRCON_RV[IRCON_IEX5],
              IRCON_RV[IRCON_IEX4], IRCON_RV[IRCON_IEX3], IRCON_RV[IRCON_IEX2]};
    else
    begin
      for (int i = 0; i < NUM_IRCON; i++)
      begin
        if (wr.wr)
          iex[i] <= wr.data[i];         // CPU write wins
        else if (ack[i])
          iex[i] <= 1'b0;
        else if (pend[i])
          iex[i] <= 1'b1;               // One cycle behind the edge
      end
    end
  end

  assign stat = '{iex: iex, fr: fr};

  // An acked flag stays down next cycle unless the CPU wrote it
  a_ack_clears: assert property (
    @(posedge clkper) disable iff (rst)
    (|ack && !wr.wr) |=> ((iex & $past(ack)) == '0)
  );

endmodule

`default_nettype wire

//--- logic/pin_sampler.sv
`timescale 1ns/10ps
`default_nettype none

module pin_sampler
  import extint_pkg::*;
(
  input  wire logic                clkper,
  input  wire logic                rst,
  input  wire logic [NUM_PINS-1:0] pins,   // Live pin levels
  output pin_edges_t               edges
);

  logic [NUM_PINS-1:0] smp;   // Previous cycle sample

  // ----------------------------------------
  // Sample registers
  // ----------------------------------------
  always_ff @(posedge clkper)
  begin
    if (rst)
      smp <= PIN_SAMPLE_RV;
    else
      smp <= pins;
  end

  // Live pin against last sample
  assign edges = '{
    rise: pins & ~smp,   // Was low, now high
    fall: ~pins & smp    // Was high, now low
  };

  // A pin moves one way per cycle
  a_one_dir: assert property (
    @(posedge clkper) disable iff (rst) (edges.rise & edges.fall) == '0
  );

endmodule

`default_nettype wire

//--- logic/sfr_map_pkg.sv
`default_nettype none

package sfr_map_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------
  localparam int SFR_ADDR_W = 7;   // SFR space 0x80..0xff, top bit dropped
  localparam int SFR_DATA_W = 8;

  // Register addresses, offset from 0x80
  localparam logic [SFR_ADDR_W-1:0] TCON_ID  = 7'h08;  // 0x88
  localparam logic [SFR_ADDR_W-1:0] IRCON_ID = 7'h40;  // 0xc0
  localparam logic [SFR_ADDR_W-1:0] T2CON_ID = 7'h48;  // 0xc8

  // Reset values
  localparam logic [SFR_DATA_W-1:0] TCON_RV  = 8'h00;
  localparam logic [SFR_DATA_W-1:0] T2CON_RV = 8'h00;
  localparam logic [SFR_DATA_W-1:0] IRCON_RV = 8'h00;

  // ----------------------------------------
  // Bit positions
  // ----------------------------------------
  localparam int TCON_IT0   = 0;   // Int 0 edge/level select
  localparam int TCON_IE0   = 1;   // Int 0 request flag
  localparam int TCON_IT1   = 2;   // Int 1 edge/level select
  localparam int TCON_IE1   = 3;   // Int 1 request flag

  localparam int T2CON_I2FR = 5;   // Int 2 rising/falling select
  localparam int T2CON_I3FR = 6;   // Int 3 rising/falling select

  localparam int IRCON_IEX7 = 0;   // Int 7 sits below the others
  localparam int IRCON_IEX2 = 1;
  localparam int IRCON_IEX3 = 2;
  localparam int IRCON_IEX4 = 3;
  localparam int IRCON_IEX5 = 4;
  localparam int IRCON_IEX6 = 5;

endpackage

`default_nettype wire

//--- logic/tcon_bank.sv
`timescale 1ns/10ps
`default_nettype none

module tcon_bank
  import sfr_map_pkg::*, extint_pkg::*;
(
  input  wire logic                clkper,
  input  wire logic                rst,
  input  wire logic                newinstr,  // Start of CPU instruction
  input  wire logic [NUM_TCON-1:0] lvl,       // Live pins 0 and 1
  input  wire logic [NUM_TCON-1:0] fall,      // Falling edge pulses
  input  wire logic [NUM_TCON-1:0] ack,       // Interrupt taken
  input  wire logic [NUM_TCON-1:0] it,        // Edge mode when set
  input  wire flag_wr_t            wr,
  output tcon_stat_t               stat
);

  logic [NUM_TCON-1:0] ie;     // Request flags
  logic [NUM_TCON-1:0] pend;   // Falling edge seen
  logic [NUM_TCON-1:0] clr;    // Ack seen, hold ie clear

  // ----------------------------------------
  // Request flags
  // ----------------------------------------
  always_ff @(posedge clkper)
  begin
    if (rst)
      ie <= {TCON_RV[TCON_IE1], TCON_RV[TCON_IE0]};
    else
    begin
      for (int i = 0; i < NUM_TCON; i++)
      begin
        if (wr.wr)
          ie[i] <= wr.data[i];          // CPU write wins
        else if (!it[i])
          ie[i] <= ~lvl[i];             // Low level request
        else if (ack[i] || clr[i])
          ie[i] <= 1'b0;
        else if (pend[i] || fall[i])
          ie[i] <= 1'b1;                // Falling edge request
      end
    end
  end

  // ----------------------------------------
  // Edge and ack latches
  // ----------------------------------------
  always_ff @(posedge clkper)
  begin
    if (rst)
    begin
      pend <= '0;
      clr  <= '0;
    end
    else
    begin
      for (int i = 0; i < NUM_TCON; i++)
      begin
        // New edge beats a clear in the same cycle
        if (fall[i])
          pend[i] <= 1'b1;
        else if (newinstr || ack[i])
          pend[i] <= 1'b0;

        if (ack[i])
          clr[i] <= 1'b1;
        else if (newinstr)
          clr[i] <= 1'b0;               // Released at next instruction
      end
    end
  end

  assign stat = '{ie: ie, it: it};

endmodule

`default_nettype wire
